/* Makefile */
# Verilator build and run of the mesh configuration testbench
SRCS = $(wildcard *.sv)

obj_dir/Vtb_mesh_cfg: flist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mesh_cfg -f flist.f

run: obj_dir/Vtb_mesh_cfg
	obj_dir/Vtb_mesh_cfg

clean:
	rm -rf obj_dir

.PHONY: run clean

/* cfg_regs.sv */
/*
 config register bank
 four 32-bit registers on the register bus, word addressed by addr[3:2]
 readback is combinational and reads as zero while en is low
*/
`timescale 1ns/1ps

module cfg_regs (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   en,
   input  logic                   we,
   input  mesh_cfg_pkg::mi_addr_t addr,
   input  mesh_cfg_pkg::mi_word_t din,
   output mesh_cfg_pkg::mi_word_t dout
);

   // register storage
   mesh_cfg_pkg::data_t regs [mesh_cfg_pkg::cfg_regs_n];

   // word select
   logic [1:0] idx;
   logic       wr_en;

   assign idx   = addr[3:2];
   assign wr_en = en & we;

   // write port, low word of din only
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < mesh_cfg_pkg::cfg_regs_n; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (wr_en)
      begin
         regs[idx] <= din[31:0];
      end
   end

   // readback
   // upper half always zero, whole word zero when not selected
   always_comb
   begin
      dout = '0;
      if (en)
      begin
         dout[31:0] = regs[idx];
      end
   end

endmodule

/* dma_regs.sv */
/*
 dma register bank
 eight 32-bit registers, word addressed by addr[4:2]
 only storage and readback, no dma engine behind them
 readback reads as zero while en is low
*/
`timescale 1ns/1ps

module dma_regs (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   en,
   input  logic                   we,
   input  mesh_cfg_pkg::mi_addr_t addr,
   input  mesh_cfg_pkg::mi_word_t din,
   output mesh_cfg_pkg::mi_word_t dout
);

   // register storage
   mesh_cfg_pkg::data_t regs [mesh_cfg_pkg::dma_regs_n];

   // word select, bit 5 is the tx/rx half and is decoded upstream
   logic [2:0] idx;

   assign idx = addr[4:2];

   // write port
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < mesh_cfg_pkg::dma_regs_n; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (en && we)
      begin
         regs[idx] <= din[31:0];
      end
   end

   // gated readback, data in the low word
   always_comb
   begin
      dout = '0;
      if (en)
      begin
         dout[31:0] = regs[idx];
      end
   end

endmodule

/* ecfg_if.sv */
/*
 packet side of the configuration block
 decodes incoming packets into register accesses, and registers the
 read reply or the forwarded packet in an output stage held by wait_in
 rx_side picks which half of the address map this instance serves
*/
`timescale 1ns/1ps

module ecfg_if #(
   parameter bit rx_side = 1'b0
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   access_in,
   input  mesh_cfg_pkg::packet_t  packet_in,
   input  logic                   wait_in,
   input  mesh_cfg_pkg::mi_word_t cfg_dout,
   input  mesh_cfg_pkg::mi_word_t dma_dout,
   input  mesh_cfg_pkg::mi_word_t mmu_dout,
   output logic                   access_out,
   output mesh_cfg_pkg::packet_t  packet_out,
   output logic                   mi_cfg_en,
   output logic                   mi_dma_en,
   output logic                   mi_mmu_en,
   output logic                   mi_we,
   output mesh_cfg_pkg::mi_addr_t mi_addr,
   output mesh_cfg_pkg::mi_word_t mi_din
);

   // unpacked request fields
   logic                    pkt_write;
   mesh_cfg_pkg::datamode_t pkt_datamode;
   mesh_cfg_pkg::ctrlmode_t pkt_ctrlmode;
   mesh_cfg_pkg::addr_t     pkt_dstaddr;
   mesh_cfg_pkg::data_t     pkt_data;
   mesh_cfg_pkg::addr_t     pkt_srcaddr;

   // decode
   logic [3:0]              group;
   logic                    chip_match;
   logic                    mi_en;
   logic                    mi_rd;
   logic                    fwd;

   // output stage inputs
   mesh_cfg_pkg::mi_word_t  readback;
   mesh_cfg_pkg::packet_t   reply_pkt;
   mesh_cfg_pkg::packet_t   next_pkt;
   logic                    next_access;

   // split the packet
   assign pkt_write    = packet_in[mesh_cfg_pkg::write_bit];
   assign pkt_datamode = packet_in[mesh_cfg_pkg::datamode_msb:mesh_cfg_pkg::datamode_lsb];
   assign pkt_ctrlmode = packet_in[mesh_cfg_pkg::ctrlmode_msb:mesh_cfg_pkg::ctrlmode_lsb];
   assign pkt_dstaddr  = packet_in[mesh_cfg_pkg::dstaddr_msb:mesh_cfg_pkg::dstaddr_lsb];
   assign pkt_data     = packet_in[mesh_cfg_pkg::data_msb:mesh_cfg_pkg::data_lsb];
   assign pkt_srcaddr  = packet_in[mesh_cfg_pkg::srcaddr_msb:mesh_cfg_pkg::srcaddr_lsb];

   // only packets for this node are looked at
   assign chip_match = access_in & (pkt_dstaddr[31:20] == mesh_cfg_pkg::chip_id);
   assign group      = pkt_dstaddr[19:16];

   // config bank, codes 010 (tx) and 011 (rx)
   assign mi_cfg_en = chip_match &
                      (group == mesh_cfg_pkg::group_cfg) &
                      (pkt_dstaddr[10:8] == {2'b01, rx_side});

   // dma bank, half chosen by bit 5
   assign mi_dma_en = chip_match &
                      (group == mesh_cfg_pkg::group_cfg) &
                      (pkt_dstaddr[10:8] == mesh_cfg_pkg::dma_sel) &
                      (pkt_dstaddr[5] == rx_side);

   // mmu table, half chosen by bit 15
   assign mi_mmu_en = chip_match &
                      (group == mesh_cfg_pkg::group_mmu) &
                      (pkt_dstaddr[15] == rx_side);

   assign mi_en = mi_cfg_en | mi_dma_en | mi_mmu_en;
   assign mi_we = pkt_write & mi_en;
   assign mi_rd = ~pkt_write & mi_en;

   // our chip and a register group, but the other half owns it
   assign fwd = chip_match &
                ((group == mesh_cfg_pkg::group_mmu) | (group == mesh_cfg_pkg::group_cfg)) &
                ~mi_en;

   // register bus
   assign mi_addr = pkt_dstaddr[14:0];
   assign mi_din  = {pkt_srcaddr, pkt_data};

   // idle targets drive zero, so a plain OR is the mux
   assign readback = cfg_dout | dma_dout | mmu_dout;

   // read reply goes back to the requester
   always_comb
   begin
      reply_pkt = '0;
      reply_pkt[mesh_cfg_pkg::write_bit] = 1'b1;
      reply_pkt[mesh_cfg_pkg::rsvd_bit]  = 1'b0;
      reply_pkt[mesh_cfg_pkg::datamode_msb:mesh_cfg_pkg::datamode_lsb] = pkt_datamode;
      reply_pkt[mesh_cfg_pkg::ctrlmode_msb:mesh_cfg_pkg::ctrlmode_lsb] = pkt_ctrlmode;
      reply_pkt[mesh_cfg_pkg::dstaddr_msb:mesh_cfg_pkg::dstaddr_lsb]   = pkt_srcaddr;
      reply_pkt[mesh_cfg_pkg::data_msb:mesh_cfg_pkg::data_lsb]         = readback[31:0];
      reply_pkt[mesh_cfg_pkg::srcaddr_msb:mesh_cfg_pkg::srcaddr_lsb]   = readback[63:32];
   end

   // forwarded packets pass untouched
   assign next_pkt    = fwd ? packet_in : reply_pkt;
   assign next_access = fwd | mi_rd;

   // output valid, held while the sink stalls
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         access_out <= 1'b0;
      else if (!wait_in)
         access_out <= next_access;
   end

   // output payload
   always_ff @(posedge clk)
   begin
      if (!wait_in && next_access)
         packet_out <= next_pkt;
   end

endmodule

/* flist.f */
mesh_cfg_pkg.sv
cfg_regs.sv
dma_regs.sv
mmu_table.sv
ecfg_if.sv
mesh_cfg_top.sv
mesh_cfg_assertions.sv
tb_mesh_cfg.sv

/* mesh_cfg_assertions.sv */
/*
 protocol checks on the configuration interface, bound into mesh_cfg_top
 covers the output state in reset, output hold under wait_in and
 the register target enables
*/
`timescale 1ns/1ps

module mesh_cfg_assertions (
   input logic                  clk,
   input logic                  reset,
   input logic                  access_out,
   input mesh_cfg_pkg::packet_t packet_out,
   input logic                  wait_in,
   input logic                  mi_cfg_en,
   input logic                  mi_dma_en,
   input logic                  mi_mmu_en
);

   // no valid output while in reset
   out_idle_in_reset: assert property (@(posedge clk) reset |-> !access_out)
      else $error("access_out high during reset");

   // a stalled output item stays put
   out_held_on_wait: assert property (
      @(posedge clk) disable iff (reset)
      (access_out && wait_in) |=> (access_out && $stable(packet_out)))
      else $error("output item changed while wait_in was high");

   // at most one target selected
   one_target: assert property (
      @(posedge clk) disable iff (reset)
      $onehot0({mi_cfg_en, mi_dma_en, mi_mmu_en}))
      else $error("more than one register target enabled");

endmodule

/* mesh_cfg_pkg.sv */
/*
 shared definitions for the mesh node configuration interface
 packet field positions, node chip id, address map codes and the
 vector types used on the packet link and the register bus
*/
package mesh_cfg_pkg;

   // packet width on the access/wait link
   localparam int pkt_w = 104;

   // field positions inside a packet
   localparam int write_bit    = 0;
   localparam int datamode_lsb = 1;
   localparam int datamode_msb = 2;
   localparam int rsvd_bit     = 3;
   localparam int ctrlmode_lsb = 4;
   localparam int ctrlmode_msb = 7;
   localparam int dstaddr_lsb  = 8;
   localparam int dstaddr_msb  = 39;
   localparam int data_lsb     = 40;
   localparam int data_msb     = 71;
   localparam int srcaddr_lsb  = 72;
   localparam int srcaddr_msb  = 103;

   // node id, compared with dstaddr[31:20]
   localparam logic [11:0] chip_id = 12'h810;

   // group codes in dstaddr[19:16]
   localparam logic [3:0] group_cfg = 4'hF;
   localparam logic [3:0] group_mmu = 4'hE;

   // dma code in dstaddr[10:8]
   localparam logic [2:0] dma_sel = 3'd5;

   // register counts per target
   localparam int cfg_regs_n    = 4;
   localparam int dma_regs_n    = 8;
   localparam int mmu_entries_n = 16;

   typedef logic [pkt_w-1:0] packet_t;
   typedef logic [31:0]      addr_t;
   typedef logic [31:0]      data_t;
   typedef logic [1:0]       datamode_t;
   typedef logic [3:0]       ctrlmode_t;
   // register offset, dstaddr[14:0]
   typedef logic [14:0]      mi_addr_t;
   // {srcaddr, data} on writes, {hi, lo} on readback
   typedef logic [63:0]      mi_word_t;

endpackage

/* mesh_cfg_top.sv */
/*
 configuration interface of a mesh node
 packet interface stage plus the config, dma and mmu register targets
 rx_side selects the transmit (0) or receive (1) half of the map
*/
`timescale 1ns/1ps

module mesh_cfg_top #(
   parameter bit rx_side = 1'b0
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  access_in,
   input  mesh_cfg_pkg::packet_t packet_in,
   input  logic                  wait_in,
   output logic                  access_out,
   output mesh_cfg_pkg::packet_t packet_out,
   output logic                  wait_out
);

   // register bus
   logic                   mi_cfg_en;
   logic                   mi_dma_en;
   logic                   mi_mmu_en;
   logic                   mi_we;
   mesh_cfg_pkg::mi_addr_t mi_addr;
   mesh_cfg_pkg::mi_word_t mi_din;

   // per-target readback
   mesh_cfg_pkg::mi_word_t cfg_dout;
   mesh_cfg_pkg::mi_word_t dma_dout;
   mesh_cfg_pkg::mi_word_t mmu_dout;

   // input stalls exactly when the output stalls
   assign wait_out = wait_in;

   ecfg_if #(
      .rx_side (rx_side)
   ) ecfg_if_i (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .cfg_dout   (cfg_dout),
      .dma_dout   (dma_dout),
      .mmu_dout   (mmu_dout),
      .access_out (access_out),
      .packet_out (packet_out),
      .mi_cfg_en  (mi_cfg_en),
      .mi_dma_en  (mi_dma_en),
      .mi_mmu_en  (mi_mmu_en),
      .mi_we      (mi_we),
      .mi_addr    (mi_addr),
      .mi_din     (mi_din)
   );

   cfg_regs cfg_regs_i (
      .clk   (clk),
      .reset (reset),
      .en    (mi_cfg_en),
      .we    (mi_we),
      .addr  (mi_addr),
      .din   (mi_din),
      .dout  (cfg_dout)
   );

   dma_regs dma_regs_i (
      .clk   (clk),
      .reset (reset),
      .en    (mi_dma_en),
      .we    (mi_we),
      .addr  (mi_addr),
      .din   (mi_din),
      .dout  (dma_dout)
   );

   mmu_table mmu_table_i (
      .clk   (clk),
      .reset (reset),
      .en    (mi_mmu_en),
      .we    (mi_we),
      .addr  (mi_addr),
      .din   (mi_din),
      .dout  (mmu_dout)
   );

endmodule

/* mmu_table.sv */
/*
 mmu translation table
 sixteen 64-bit entries, indexed by addr[6:3]
 a write stores {srcaddr, data} whole, readback returns the full entry
*/
`timescale 1ns/1ps

module mmu_table (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   en,
   input  logic                   we,
   input  mesh_cfg_pkg::mi_addr_t addr,
   input  mesh_cfg_pkg::mi_word_t din,
   output mesh_cfg_pkg::mi_word_t dout
);

   // entry storage
   mesh_cfg_pkg::mi_word_t table_q [mesh_cfg_pkg::mmu_entries_n];

   // entry select, 8-byte entries
   logic [3:0] idx;

   assign idx = addr[6:3];

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < mesh_cfg_pkg::mmu_entries_n; i++)
         begin
            table_q[i] <= '0;
         end
      end
      else if (en && we)
      begin
         table_q[idx] <= din;
      end
   end

   // zero unless selected
   assign dout = en ? table_q[idx] : '0;

endmodule

/* tb_mesh_cfg.sv */
/*
 testbench for the mesh node configuration interface
 sends request packets over the access/wait link, models the register
 targets in shadow arrays and checks every reply and forward in order
 ends with a mixed run under random back-pressure from the sink
*/
`timescale 1ns/1ps

module tb_mesh_cfg;

   localparam bit rx_side    = 1'b0;
   localparam int clk_period = 20;
   localparam int n_mixed    = 64;
   // cfg 8, dma 16, mmu 32, forward 6, drop 6, then the mixed run
   localparam int n_requests = 8 + 16 + 32 + 6 + 6 + n_mixed;
   // cycles allowed for the last outputs to come out after the final request
   localparam int drain_limit = 20;

   // target codes of the reference decode
   localparam int tgt_none = 0;
   localparam int tgt_cfg  = 1;
   localparam int tgt_dma  = 2;
   localparam int tgt_mmu  = 3;

   logic                  clk = 1'b0;
   logic                  reset;
   logic                  access_in;
   mesh_cfg_pkg::packet_t packet_in;
   logic                  wait_in = 1'b0;
   logic                  access_out;
   mesh_cfg_pkg::packet_t packet_out;
   logic                  wait_out;

   integer seed      = 32'hc4fe_7f15;
   logic   bp_enable = 1'b0;
   string  test_name = "reset";

   // shadow copies of the targets
   mesh_cfg_pkg::data_t    cfg_shadow [4];
   mesh_cfg_pkg::data_t    dma_shadow [8];
   mesh_cfg_pkg::mi_word_t mmu_shadow [16];

   // expected output packets in arrival order and the test of each
   mesh_cfg_pkg::packet_t exp_q [$];
   string                 name_q [$];

   mesh_cfg_top #(
      .rx_side (rx_side)
   ) dut_i (
      .clk        (clk),
      .reset      (reset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_in    (wait_in),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_out   (wait_out)
   );

   bind mesh_cfg_top mesh_cfg_assertions assertions_i (
      .clk        (clk),
      .reset      (reset),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .mi_cfg_en  (mi_cfg_en),
      .mi_dma_en  (mi_dma_en),
      .mi_mmu_en  (mi_mmu_en)
   );

   always #(clk_period / 2) clk = ~clk;

   task automatic fail_run(input string why);
      $display("SOME TESTS FAILED");
      $fatal(1, "%s", why);
   endtask

   function automatic logic [31:0] next_random();
      return $random(seed);
   endfunction

   // srcaddr, data, dstaddr, ctrlmode, reserved zero, datamode, write
   function automatic mesh_cfg_pkg::packet_t build_packet(
      input logic wr, input logic [1:0] dmode, input logic [3:0] cmode,
      input mesh_cfg_pkg::addr_t dst, input mesh_cfg_pkg::data_t data,
      input mesh_cfg_pkg::addr_t src);
      return {src, data, dst, cmode, 1'b0, dmode, wr};
   endfunction

   function automatic mesh_cfg_pkg::addr_t cfg_address(input logic [1:0] idx, input bit half);
      return {mesh_cfg_pkg::chip_id, mesh_cfg_pkg::group_cfg, 5'b0, 2'b01, half,
              4'h0, idx, 2'b00};
   endfunction

   function automatic mesh_cfg_pkg::addr_t dma_address(input logic [2:0] idx, input bit half);
      return {mesh_cfg_pkg::chip_id, mesh_cfg_pkg::group_cfg, 5'b0, mesh_cfg_pkg::dma_sel,
              2'b00, half, idx, 2'b00};
   endfunction

   function automatic mesh_cfg_pkg::addr_t mmu_address(input logic [3:0] idx, input bit half);
      return {mesh_cfg_pkg::chip_id, mesh_cfg_pkg::group_mmu, half, 8'h00, idx, 3'b000};
   endfunction

   // which of our targets a dstaddr selects
   function automatic int target_of(input mesh_cfg_pkg::addr_t dst);
      if (dst[31:20] != mesh_cfg_pkg::chip_id)
         return tgt_none;
      if (dst[19:16] == mesh_cfg_pkg::group_cfg && dst[10:8] == {2'b01, rx_side})
         return tgt_cfg;
      if (dst[19:16] == mesh_cfg_pkg::group_cfg && dst[10:8] == mesh_cfg_pkg::dma_sel &&
          dst[5] == rx_side)
         return tgt_dma;
      if (dst[19:16] == mesh_cfg_pkg::group_mmu && dst[15] == rx_side)
         return tgt_mmu;
      return tgt_none;
   endfunction

   // reference model that returns 1 when the request gives an output packet
   function automatic bit expected_output(input mesh_cfg_pkg::packet_t req,
                                          output mesh_cfg_pkg::packet_t rsp);
      mesh_cfg_pkg::addr_t    dst;
      mesh_cfg_pkg::mi_word_t rb;
      int                     tgt;
      dst = req[39:8];
      tgt = target_of(dst);
      rsp = req;
      // register group on our chip but not our half is forwarded as is
      if (tgt == tgt_none)
         return dst[31:20] == mesh_cfg_pkg::chip_id &&
                (dst[19:16] == mesh_cfg_pkg::group_cfg || dst[19:16] == mesh_cfg_pkg::group_mmu);
      if (req[0])
         return 1'b0;
      case (tgt)
         tgt_cfg: rb = {32'h0, cfg_shadow[dst[3:2]]};
         tgt_dma: rb = {32'h0, dma_shadow[dst[4:2]]};
         default: rb = mmu_shadow[dst[6:3]];
      endcase
      // reply goes to the requester's srcaddr
      rsp = build_packet(1'b1, req[2:1], req[7:4], req[103:72], rb[31:0], rb[63:32]);
      return 1'b1;
   endfunction

   function automatic void update_shadow(input mesh_cfg_pkg::packet_t req);
      mesh_cfg_pkg::addr_t dst;
      dst = req[39:8];
      if (req[0])
      begin
         case (target_of(dst))
            tgt_cfg: cfg_shadow[dst[3:2]] = req[71:40];
            tgt_dma: dma_shadow[dst[4:2]] = req[71:40];
            tgt_mmu: mmu_shadow[dst[6:3]] = {req[103:72], req[71:40]};
            default: ;
         endcase
      end
   endfunction

   task automatic send_request(input mesh_cfg_pkg::packet_t pkt);
      mesh_cfg_pkg::packet_t exp_pkt;
      access_in <= 1'b1;
      packet_in <= pkt;
      // taken at the first edge where the link is not stalled
      @(posedge clk);
      while (wait_out)
         @(posedge clk);
      if (expected_output(pkt, exp_pkt))
      begin
         exp_q.push_back(exp_pkt);
         name_q.push_back(test_name);
      end
      update_shadow(pkt);
   endtask

   // random modes, data and srcaddr
   task automatic send_random(input logic wr, input mesh_cfg_pkg::addr_t dst);
      logic [31:0] r;
      r = next_random();
      send_request(build_packet(wr, r[1:0], r[5:2], dst, next_random(), next_random()));
   endtask

   // sink stalls about one cycle in four
   always @(posedge clk)
   begin
      if (bp_enable)
         wait_in <= next_random() < 32'h4000_0000;
      else
         wait_in <= 1'b0;
   end

   // compare every item the sink takes
   always @(posedge clk)
   begin : compare
      mesh_cfg_pkg::packet_t exp_pkt;
      string                 exp_name;
      // the source side stalls together with the sink
      assert (wait_out === wait_in)
         else
         begin
            $display("Error: test %s expected wait_out %b actual %b",
                     test_name, wait_in, wait_out);
            fail_run("wait_out does not follow wait_in");
         end
      if (!reset && access_out && !wait_in)
      begin
         assert (exp_q.size() != 0)
            else fail_run("an output packet arrived while none was expected");
         exp_pkt  = exp_q.pop_front();
         exp_name = name_q.pop_front();
         assert (packet_out === exp_pkt)
            else
            begin
               $display("Error: test %s expected %h actual %h", exp_name, exp_pkt, packet_out);
               fail_run("output packet mismatch");
            end
      end
   end

   // watchdog allows 20 cycles per request
   initial
   begin
      #(n_requests * 20 * clk_period);
      fail_run("timeout, the run did not finish in time");
   end

   initial
   begin : stimulus
      mesh_cfg_pkg::addr_t dst;
      logic [31:0]         r;
      int                  drain_cycles;
      reset      <= 1'b1;
      access_in  <= 1'b0;
      packet_in  <= '0;
      cfg_shadow = '{default: '0};
      dma_shadow = '{default: '0};
      mmu_shadow = '{default: '0};
      repeat (5) @(posedge clk);
      reset <= 1'b0;

      test_name = "cfg_write_read";
      for (int i = 0; i < 4; i++)
         send_random(1'b1, cfg_address(i[1:0], rx_side));
      for (int i = 0; i < 4; i++)
         send_random(1'b0, cfg_address(i[1:0], rx_side));

      test_name = "dma_write_read";
      for (int i = 0; i < 8; i++)
         send_random(1'b1, dma_address(i[2:0], rx_side));
      for (int i = 0; i < 8; i++)
         send_random(1'b0, dma_address(i[2:0], rx_side));

      test_name = "mmu_write_read";
      for (int i = 0; i < 16; i++)
         send_random(1'b1, mmu_address(i[3:0], rx_side));
      for (int i = 0; i < 16; i++)
         send_random(1'b0, mmu_address(i[3:0], rx_side));

      // receive half of the map
      test_name = "forward";
      for (int i = 0; i < 2; i++)
      begin
         send_random(i[0], cfg_address(2'd1, ~rx_side));
         send_random(i[0], dma_address(3'd3, ~rx_side));
         send_random(i[0], mmu_address(4'd7, ~rx_side));
      end

      test_name = "drop";
      dst = cfg_address(2'd1, rx_side);
      dst[31:20] = 12'h811;
      send_random(1'b1, dst);
      send_random(1'b0, dst);
      dst = mmu_address(4'd2, rx_side);
      dst[19:16] = 4'hA;
      send_random(1'b1, dst);
      send_random(1'b0, dst);
      // old contents must still be there
      send_random(1'b0, cfg_address(2'd1, rx_side));
      send_random(1'b0, mmu_address(4'd2, rx_side));

      test_name = "back_pressure";
      bp_enable <= 1'b1;
      for (int i = 0; i < n_mixed; i++)
      begin
         r = next_random();
         case (r[2:0])
            3'd0, 3'd1: dst = cfg_address(r[4:3], rx_side);
            3'd2, 3'd3: dst = dma_address(r[5:3], rx_side);
            3'd4, 3'd5: dst = mmu_address(r[6:3], rx_side);
            // other half is forwarded
            3'd6: dst = mmu_address(r[6:3], ~rx_side);
            default:
            begin
               dst = cfg_address(r[4:3], rx_side);
               dst[19:16] = 4'h3;
            end
         endcase
         send_random(r[8], dst);
      end

      // drain the queue and then look for stray outputs
      access_in <= 1'b0;
      bp_enable <= 1'b0;
      drain_cycles = 0;
      while (exp_q.size() != 0 && drain_cycles < drain_limit)
      begin
         @(posedge clk);
         drain_cycles++;
      end
      repeat (5) @(posedge clk);
      if (exp_q.size() == 0)
      begin
         $display("ALL TESTS PASSED");
         $finish;
      end
      else
         fail_run("some expected output packets never arrived");
   end

endmodule
